// File: design/tlbBusPkg.sv
// TLB request bus definitions
// opcodes, bus widths and the untranslated physical window
`default_nettype none

package tlbBusPkg;

	// bus widths
	localparam int addrWidth = 32;
	localparam int seqWidth = 16;
	localparam int opWidth = 8;

	// request opcodes, low byte of the ring bus opm field
	localparam logic [opWidth-1:0] opIdle = 8'h00;
	localparam logic [opWidth-1:0] opLoad = 8'h91;
	localparam logic [opWidth-1:0] opStore = 8'hA1;
	localparam logic [opWidth-1:0] opLdtlb = 8'h61;
	localparam logic [opWidth-1:0] opInvtlb = 8'h62;

	// top nibble that marks an address as already physical
	localparam logic [3:0] physWindowTag = 4'hC;

	// base of the page that a missing access is redirected to
	localparam logic [addrWidth-1:0] missVector = 32'h0001_0000;

endpackage

`default_nettype wire

// File: design/tlbEntryPkg.sv
// TLB entry and array geometry
// entry layout, set type and the set index hash
`default_nettype none

package tlbEntryPkg;

	// 4 KB pages over a 32-bit address
	localparam int pageBits = 12;
	localparam int vpnWidth = 20;
	localparam int ppnWidth = 20;

	// 64 sets of four ways
	localparam int setCount = 64;
	localparam int indexWidth = 6;
	localparam int wayCount = 4;

	// one translation, 40 bits
	typedef struct packed {
		logic [vpnWidth-1:0] vpn;
		logic [ppnWidth-1:0] ppn;
	} tlbEntry;

	// way 0 is the most recently used entry
	typedef tlbEntry [wayCount-1:0] tlbSet;

	// fold the middle VPN bits into the low ones so that
	// neighbouring regions spread over the sets
	function automatic logic [indexWidth-1:0] tlbIndexHash(
		input logic [vpnWidth-1:0] vpn
	);
		logic [indexWidth-1:0] lowBits;
		logic [indexWidth-1:0] highBits;

		lowBits = vpn[indexWidth-1:0];
		highBits = vpn[2*indexWidth-1:indexWidth];
		return lowBits ^ highBits;
	endfunction

endpackage

`default_nettype wire

// File: design/tlbStageIf.sv
// Internal TLB buses
// request to match stage, set read path and set write path
`timescale 1ns/1ps
`default_nettype none

interface tlbStageIf;
	import tlbBusPkg::*;
	import tlbEntryPkg::*;

	logic [opWidth-1:0] op;
	logic [addrWidth-1:0] vaddr;
	logic [seqWidth-1:0] seq;
	logic [ppnWidth-1:0] loadPpn;
	// set when the address goes out untranslated
	logic bypass;

	modport source(output op, vaddr, seq, loadPpn, bypass);
	modport sink(input op, vaddr, seq, loadPpn, bypass);
endinterface

interface tlbReadIf;
	import tlbEntryPkg::*;

	logic [indexWidth-1:0] index;
	tlbSet readSet;
	logic [wayCount-1:0] readValid;

	modport request(output index);
	modport store(input index, output readSet, readValid);
	modport match(input readSet, readValid);
endinterface

interface tlbWriteIf;
	import tlbEntryPkg::*;

	logic writeEnable;
	logic [indexWidth-1:0] writeIndex;
	tlbSet writeSet;
	// valid bits of the set after the write
	logic [wayCount-1:0] writeValid;
	logic clearAll;

	modport source(output writeEnable, writeIndex, writeSet, writeValid, clearAll);
	modport store(input writeEnable, writeIndex, writeSet, writeValid, clearAll);
endinterface

`default_nettype wire

// File: design/tlbRequestStage.sv
// TLB request stage
// latches the incoming request, decides on bypass and starts the set read
`timescale 1ns/1ps
`default_nettype none

module tlbRequestStage (
	input logic clock,
	input logic reset,
	input logic hold,
	input logic mmuEnable,
	input logic [tlbBusPkg::opWidth-1:0] reqOp,
	input logic [tlbBusPkg::addrWidth-1:0] reqAddr,
	input logic [tlbBusPkg::addrWidth-1:0] reqData,
	input logic [tlbBusPkg::seqWidth-1:0] reqSeq,
	tlbStageIf.source stage,
	tlbReadIf.request read
);
	import tlbBusPkg::*;
	import tlbEntryPkg::*;

	logic isAccess;
	logic inWindow;
	logic [vpnWidth-1:0] reqVpn;

	assign isAccess = (reqOp == opLoad) || (reqOp == opStore);
	assign inWindow = (reqAddr[addrWidth-1:addrWidth-4] == physWindowTag);
	assign reqVpn = reqAddr[addrWidth-1:pageBits];

	// the set read uses the live address so the store
	// latches it on the same edge as the request
	assign read.index = tlbIndexHash(reqVpn);

	always_ff @(posedge clock)
	begin
		if (reset)
			stage.op <= opIdle;
		else if (!hold)
			stage.op <= reqOp;
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			stage.vaddr <= reqAddr;
			stage.seq <= reqSeq;
			// LDTLB carries the new PPN in the low data bits
			stage.loadPpn <= reqData[ppnWidth-1:0];
			stage.bypass <= !mmuEnable || inWindow || !isAccess;
		end
	end

endmodule

`default_nettype wire

// File: design/tlbWayStore.sv
// TLB way store
// 64 sets of four entries with a synchronous set read,
// whole-set writes and a per-way valid bitmap
`timescale 1ns/1ps
`default_nettype none

module tlbWayStore (
	input logic clock,
	input logic reset,
	input logic hold,
	tlbReadIf.store read,
	tlbWriteIf.store write
);
	import tlbEntryPkg::*;

	tlbSet setMem [setCount];
	logic [setCount-1:0][wayCount-1:0] validBits;
	logic writeAllowed;

	// nothing changes in the array while the pipeline is frozen
	assign writeAllowed = !hold;

	// read register follows the request stage
	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			read.readSet <= setMem[read.index];
			read.readValid <= validBits[read.index];
		end
	end

	// entry array, small enough for distributed memory
	always_ff @(posedge clock)
	begin
		if (writeAllowed && write.writeEnable)
			setMem[write.writeIndex] <= write.writeSet;
	end

	// valid bitmap
	always_ff @(posedge clock)
	begin
		if (reset)
			validBits <= '0;
		else if (writeAllowed)
		begin
			if (write.clearAll)
				validBits <= '0;
			else if (write.writeEnable)
				validBits[write.writeIndex] <= write.writeValid;
		end
	end

endmodule

`default_nettype wire

// File: design/tlbMatchStage.sv
// TLB match stage
// compares the request against the read set, forms the response
// address and writes back loads, promotions and invalidation
`timescale 1ns/1ps
`default_nettype none

module tlbMatchStage (
	input logic clock,
	input logic reset,
	input logic hold,
	tlbStageIf.sink stage,
	tlbReadIf.match read,
	tlbWriteIf.source write,
	output logic [tlbBusPkg::opWidth-1:0] rspOp,
	output logic [tlbBusPkg::addrWidth-1:0] rspAddr,
	output logic [tlbBusPkg::seqWidth-1:0] rspSeq,
	output logic rspMiss,
	output logic [tlbBusPkg::addrWidth-1:0] rspFaultAddr
);
	import tlbBusPkg::*;
	import tlbEntryPkg::*;

	logic [vpnWidth-1:0] vpn;
	logic [pageBits-1:0] pageOffset;
	logic isLdtlb;
	logic isInvtlb;
	logic [wayCount-1:0] wayMatch;
	logic hit;
	int hitWay;
	tlbEntry hitEntry;
	logic promote;
	tlbSet newSet;
	logic [wayCount-1:0] newValid;
	logic [addrWidth-1:0] nextAddr;
	logic nextMiss;

	assign vpn = stage.vaddr[addrWidth-1:pageBits];
	assign pageOffset = stage.vaddr[pageBits-1:0];
	assign isLdtlb = (stage.op == opLdtlb);
	assign isInvtlb = (stage.op == opInvtlb);

	// tag compare, lowest matching way wins
	always_comb
	begin
		hit = 1'b0;
		hitWay = 0;
		for (int i = wayCount - 1; i >= 0; i--)
		begin
			wayMatch[i] = read.readValid[i] && (read.readSet[i].vpn == vpn);
			if (wayMatch[i])
			begin
				hit = 1'b1;
				hitWay = i;
			end
		end
	end

	assign hitEntry = read.readSet[hitWay];

	// only a translated access that hit below way 0 reorders
	assign promote = hit && !stage.bypass && (hitWay != 0);

	// new set contents
	always_comb
	begin
		newSet = read.readSet;
		newValid = read.readValid;
		if (isLdtlb)
		begin
			// oldest entry in the last way falls out
			for (int i = 1; i < wayCount; i++)
				newSet[i] = read.readSet[i-1];
			newSet[0].vpn = vpn;
			newSet[0].ppn = stage.loadPpn;
			newValid = {read.readValid[wayCount-2:0], 1'b1};
		end
		else if (promote)
		begin
			// ways above the hit move down one, the rest stay
			for (int i = 1; i < wayCount; i++)
			begin
				if (i <= hitWay)
					newSet[i] = read.readSet[i-1];
			end
			newSet[0] = hitEntry;
		end
	end

	assign write.writeEnable = isLdtlb || promote;
	assign write.writeIndex = tlbIndexHash(vpn);
	assign write.writeSet = newSet;
	assign write.writeValid = newValid;
	assign write.clearAll = isInvtlb;

	// response address
	always_comb
	begin
		nextAddr = stage.vaddr;
		nextMiss = 1'b0;
		if (isLdtlb || isInvtlb)
			nextAddr = '0;
		else if (!stage.bypass)
		begin
			if (hit)
				nextAddr = {hitEntry.ppn, pageOffset};
			else
			begin
				nextAddr = missVector + {{(addrWidth - pageBits){1'b0}}, pageOffset};
				nextMiss = 1'b1;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			rspOp <= opIdle;
			rspMiss <= 1'b0;
		end
		else if (!hold)
		begin
			rspOp <= stage.op;
			rspMiss <= nextMiss;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			rspAddr <= nextAddr;
			rspSeq <= stage.seq;
			// fault address only carries meaning on a miss
			rspFaultAddr <= nextMiss ? stage.vaddr : '0;
		end
	end

endmodule

`default_nettype wire

// File: design/mmuTlb.sv
// MMU TLB top level
// two-stage translation between the L1 and L2 caches
`timescale 1ns/1ps
`default_nettype none

module mmuTlb (
	input logic clock,
	input logic reset,
	input logic hold,
	input logic mmuEnable,
	input logic [tlbBusPkg::opWidth-1:0] reqOp,
	input logic [tlbBusPkg::addrWidth-1:0] reqAddr,
	input logic [tlbBusPkg::addrWidth-1:0] reqData,
	input logic [tlbBusPkg::seqWidth-1:0] reqSeq,
	output logic [tlbBusPkg::opWidth-1:0] rspOp,
	output logic [tlbBusPkg::addrWidth-1:0] rspAddr,
	output logic [tlbBusPkg::seqWidth-1:0] rspSeq,
	output logic rspMiss,
	output logic [tlbBusPkg::addrWidth-1:0] rspFaultAddr
);

	tlbStageIf stageBus ();
	tlbReadIf readBus ();
	tlbWriteIf writeBus ();

	tlbRequestStage requestStage0 (
		.clock(clock),
		.reset(reset),
		.hold(hold),
		.mmuEnable(mmuEnable),
		.reqOp(reqOp),
		.reqAddr(reqAddr),
		.reqData(reqData),
		.reqSeq(reqSeq),
		.stage(stageBus.source),
		.read(readBus.request)
	);

	tlbWayStore wayStore0 (
		.clock(clock),
		.reset(reset),
		.hold(hold),
		.read(readBus.store),
		.write(writeBus.store)
	);

	tlbMatchStage matchStage0 (
		.clock(clock),
		.reset(reset),
		.hold(hold),
		.stage(stageBus.sink),
		.read(readBus.match),
		.write(writeBus.source),
		.rspOp(rspOp),
		.rspAddr(rspAddr),
		.rspSeq(rspSeq),
		.rspMiss(rspMiss),
		.rspFaultAddr(rspFaultAddr)
	);

endmodule

`default_nettype wire

// File: dv/tlbModel.svh
// TLB reference model for the testbench
// software copy of every set in way order, address LFSR and test sizes
`ifndef TLB_MODEL_SVH
`define TLB_MODEL_SVH

localparam int resetCycles = 16;
localparam int sameSetGap = 2;
// requests over all six tests, rounded up
localparam int requestBudget = 100;
// a request, its idle gap and a possible hold pulse
localparam int cycleLimit = 2 * (resetCycles + requestBudget * (sameSetGap + 2));

logic [31:0] lfsrState = 32'd3;
logic [19:0] modelVpn [64][4];
logic [19:0] modelPpn [64][4];
logic modelValid [64][4];

// Fibonacci LFSR, taps 32 22 2 1, one step per bit
function automatic logic [31:0] randomBits(input int count);
	logic [31:0] value;
	logic feedback;

	value = '0;
	for (int i = 0; i < count; i++)
	begin
		feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
		lfsrState = {lfsrState[30:0], feedback};
		value = {value[30:0], feedback};
	end
	return value;
endfunction

function automatic logic [19:0] randomVpn();
	logic [31:0] bits;

	bits = randomBits(19);
	// top bit low keeps the page out of the physical window
	return {1'b0, bits[18:0]};
endfunction

// low six VPN bits folded with bits 11 to 6
function automatic logic [5:0] setOfVpn(input logic [19:0] vpn);
	return vpn[5:0] ^ vpn[11:6];
endfunction

function automatic void clearModel();
	for (int s = 0; s < 64; s++)
		for (int w = 0; w < 4; w++)
			modelValid[s][w] = 1'b0;
endfunction

function automatic void tlbModel(
	input logic [7:0] op,
	input logic [31:0] addr,
	input logic [19:0] loadPpn,
	input logic enable,
	output logic [31:0] expAddr,
	output logic expMiss
);
	logic [19:0] vpn;
	logic [5:0] setIndex;
	logic bypass;
	logic [19:0] hitPpn;
	int hitWay;

	vpn = addr[31:12];
	setIndex = setOfVpn(vpn);
	bypass = !enable || (addr[31:28] == physWindowTag) || !(op == opLoad || op == opStore);
	expAddr = addr;
	expMiss = 1'b0;
	hitWay = -1;
	if (op == opLdtlb)
	begin
		// way 3 drops out, new entry becomes way 0
		for (int w = 3; w > 0; w--)
		begin
			modelVpn[setIndex][w] = modelVpn[setIndex][w-1];
			modelPpn[setIndex][w] = modelPpn[setIndex][w-1];
			modelValid[setIndex][w] = modelValid[setIndex][w-1];
		end
		modelVpn[setIndex][0] = vpn;
		modelPpn[setIndex][0] = loadPpn;
		modelValid[setIndex][0] = 1'b1;
		expAddr = '0;
	end
	else if (op == opInvtlb)
	begin
		clearModel();
		expAddr = '0;
	end
	else if (!bypass)
	begin
		for (int w = 3; w >= 0; w--)
			if (modelValid[setIndex][w] && modelVpn[setIndex][w] == vpn)
				hitWay = w;
		if (hitWay < 0)
		begin
			expAddr = missVector + {20'h0, addr[11:0]};
			expMiss = 1'b1;
		end
		else
		begin
			hitPpn = modelPpn[setIndex][hitWay];
			// hit moves to way 0, the ways above it slide down
			for (int w = hitWay; w > 0; w--)
			begin
				modelVpn[setIndex][w] = modelVpn[setIndex][w-1];
				modelPpn[setIndex][w] = modelPpn[setIndex][w-1];
			end
			modelVpn[setIndex][0] = vpn;
			modelPpn[setIndex][0] = hitPpn;
			expAddr = {hitPpn, addr[11:0]};
		end
	end
endfunction

`endif

// File: dv/tlbTb.sv
// TLB testbench
// runs six request sequences and checks every response against the model
`timescale 1ns/1ps
`default_nettype none

module tlbTb;
	import tlbBusPkg::*;

	logic clock;
	logic reset;
	logic hold;
	logic mmuEnable;
	logic [7:0] reqOp;
	logic [31:0] reqAddr;
	logic [31:0] reqData;
	logic [15:0] reqSeq;
	logic [7:0] rspOp;
	logic [31:0] rspAddr;
	logic [15:0] rspSeq;
	logic rspMiss;
	logic [31:0] rspFaultAddr;

	`include "tlbModel.svh"

	// expected responses in issue order
	logic [15:0] expSeqQ [$];
	logic [7:0] expOpQ [$];
	logic [31:0] expAddrQ [$];
	logic expMissQ [$];
	logic [31:0] expFaultQ [$];

	string testNames [6] = '{"passThrough", "coldMiss", "loadHit",
		"setEviction", "invalidate", "holdOrder"};
	int checkCount [6];
	int errorCount [6];
	int testNow;
	int issuedCount;
	int strayCount;
	int cycleCount;
	logic mmuOn;
	logic [15:0] nextSeq;
	logic stageBusy;
	logic outputBusy;
	logic outputIdle;
	logic [19:0] vpnList [12];
	logic [19:0] ppnList [12];

	mmuTlb dut0 (
		.clock(clock),
		.reset(reset),
		.hold(hold),
		.mmuEnable(mmuEnable),
		.reqOp(reqOp),
		.reqAddr(reqAddr),
		.reqData(reqData),
		.reqSeq(reqSeq),
		.rspOp(rspOp),
		.rspAddr(rspAddr),
		.rspSeq(rspSeq),
		.rspMiss(rspMiss),
		.rspFaultAddr(rspFaultAddr)
	);

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	task automatic idleCycles(input int count);
		repeat (count)
		begin
			reqOp <= opIdle;
			reqSeq <= '0;
			hold <= 1'b0;
			@(posedge clock);
		end
	endtask

	task automatic holdPulse();
		reqOp <= opIdle;
		hold <= 1'b1;
		@(posedge clock);
	endtask

	task automatic issue(input logic [7:0] op, input logic [31:0] addr,
		input logic [19:0] ppn, input int gap);
		logic [31:0] expectedAddr;
		logic expectedMiss;

		tlbModel(op, addr, ppn, mmuOn, expectedAddr, expectedMiss);
		expSeqQ.push_back(nextSeq);
		expOpQ.push_back(op);
		expAddrQ.push_back(expectedAddr);
		expMissQ.push_back(expectedMiss);
		expFaultQ.push_back(addr);
		reqOp <= op;
		reqAddr <= addr;
		reqData <= {12'h0, ppn};
		reqSeq <= nextSeq;
		mmuEnable <= mmuOn;
		hold <= 1'b0;
		nextSeq = nextSeq + 16'd1;
		issuedCount++;
		@(posedge clock);
		idleCycles(gap);
	endtask

	task automatic finishTest();
		idleCycles(1);
		while (expSeqQ.size() != 0)
			@(posedge clock);
		$display("test %0d %s: %0d checks, %0d errors", testNow + 1, testNames[testNow],
			checkCount[testNow], errorCount[testNow]);
	endtask

	function automatic void reportValue(input string field, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("ERROR %s seq %0d %s: expected %h, actual %h", testNames[testNow], rspSeq,
			field, expected, actual);
		errorCount[testNow]++;
	endfunction

	function automatic void compareResponse();
		logic [15:0] seq;
		logic [7:0] op;
		logic [31:0] addr;
		logic miss;
		logic [31:0] fault;

		seq = expSeqQ.pop_front();
		op = expOpQ.pop_front();
		addr = expAddrQ.pop_front();
		miss = expMissQ.pop_front();
		fault = expFaultQ.pop_front();
		checkCount[testNow]++;
		if (rspSeq !== seq)
			reportValue("rspSeq", {16'h0, seq}, {16'h0, rspSeq});
		if (rspOp !== op)
			reportValue("rspOp", {24'h0, op}, {24'h0, rspOp});
		if (rspAddr !== addr)
			reportValue("rspAddr", addr, rspAddr);
		if (rspMiss !== miss)
			reportValue("rspMiss", {31'h0, miss}, {31'h0, rspMiss});
		// the fault address is the virtual address of the request
		if (miss && rspFaultAddr !== fault)
			reportValue("rspFaultAddr", fault, rspFaultAddr);
	endfunction

	// each request moves through two registers that only advance
	// on an edge without hold, its response is on the outputs after the second
	always @(posedge clock)
	begin
		if (reset)
		begin
			stageBusy = 1'b0;
			outputBusy = 1'b0;
			outputIdle = 1'b1;
		end
		else
		begin
			if (outputBusy)
			begin
				outputBusy = 1'b0;
				compareResponse();
			end
			else if (outputIdle && (rspOp !== opIdle || rspMiss !== 1'b0))
			begin
				$display("response op %h seq %0d arrived with no request outstanding",
					rspOp, rspSeq);
				strayCount++;
			end
			if (!hold)
			begin
				outputIdle = !stageBusy;
				outputBusy = stageBusy;
				stageBusy = (reqOp != opIdle);
			end
		end
	end

	initial
	begin
		cycleCount = 0;
		while (cycleCount < cycleLimit)
		begin
			@(posedge clock);
			cycleCount++;
		end
		$display("run stopped after %0d cycles with responses still outstanding", cycleCount);
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		logic [31:0] word;
		logic [19:0] vpn;
		logic [5:0] target;
		logic [19:0] setVpn [5];
		int totalChecks;
		int totalErrors;

		reset <= 1'b1;
		hold <= 1'b0;
		mmuEnable <= 1'b0;
		reqOp <= opIdle;
		reqAddr <= '0;
		reqData <= '0;
		reqSeq <= '0;
		clearModel();
		mmuOn = 1'b0;
		nextSeq = 16'd1;
		issuedCount = 0;
		strayCount = 0;
		testNow = 0;
		for (int i = 0; i < 6; i++)
		begin
			checkCount[i] = 0;
			errorCount[i] = 0;
		end
		repeat (resetCycles) @(posedge clock);
		reset <= 1'b0;

		// MMU off, then the physical window with the MMU on
		for (int i = 0; i < 16; i++)
			issue(opLoad, randomBits(32), '0, 0);
		mmuOn = 1'b1;
		for (int i = 0; i < 4; i++)
		begin
			word = randomBits(28);
			issue(opLoad, {physWindowTag, word[27:0]}, '0, 0);
		end
		finishTest();

		testNow = 1;
		for (int i = 0; i < 8; i++)
		begin
			vpn = randomVpn();
			word = randomBits(12);
			issue(opLoad, {vpn, word[11:0]}, '0, 0);
		end
		finishTest();

		testNow = 2;
		for (int i = 0; i < 12; i++)
		begin
			vpnList[i] = randomVpn();
			word = randomBits(20);
			ppnList[i] = word[19:0];
			issue(opLdtlb, {vpnList[i], 12'h0}, ppnList[i], sameSetGap);
		end
		for (int i = 0; i < 12; i++)
		begin
			word = randomBits(12);
			issue((i % 2 == 1) ? opStore : opLoad, {vpnList[i], word[11:0]}, '0, sameSetGap);
		end
		finishTest();

		// five pages in one set, the promoted first page survives the fifth load
		testNow = 3;
		word = randomBits(6);
		target = word[5:0];
		for (int k = 0; k < 5; k++)
		begin
			word = randomBits(7);
			setVpn[k] = {1'b0, word[6:0], 6'(k + 1), 6'(k + 1) ^ target};
		end
		for (int k = 0; k < 4; k++)
		begin
			word = randomBits(20);
			issue(opLdtlb, {setVpn[k], 12'h0}, word[19:0], sameSetGap);
		end
		issue(opLoad, {setVpn[0], 12'h010}, '0, sameSetGap);
		word = randomBits(20);
		issue(opLdtlb, {setVpn[4], 12'h0}, word[19:0], sameSetGap);
		for (int k = 0; k < 5; k++)
		begin
			word = randomBits(12);
			issue(opLoad, {setVpn[k], word[11:0]}, '0, sameSetGap);
		end
		finishTest();

		testNow = 4;
		issue(opInvtlb, '0, '0, sameSetGap);
		for (int i = 0; i < 4; i++)
			issue(opLoad, {vpnList[i], 12'h123}, '0, sameSetGap);
		vpn = randomVpn();
		word = randomBits(20);
		issue(opLdtlb, {vpn, 12'h0}, word[19:0], sameSetGap);
		issue(opStore, {vpn, 12'hABC}, '0, sameSetGap);
		finishTest();

		// sets 0 to 7, then back-to-back loads broken by hold pulses
		testNow = 5;
		for (int i = 0; i < 8; i++)
		begin
			word = randomBits(27);
			vpnList[i] = {1'b0, word[26:20], 6'd0, 6'(i)};
			issue(opLdtlb, {vpnList[i], 12'h0}, word[19:0], sameSetGap);
		end
		for (int i = 0; i < 8; i++)
		begin
			word = randomBits(12);
			issue(opLoad, {vpnList[i], word[11:0]}, '0, 0);
			if (i % 2 == 1)
				holdPulse();
			if (i == 4)
				holdPulse();
		end
		finishTest();

		idleCycles(2);
		totalChecks = 0;
		totalErrors = 0;
		for (int i = 0; i < 6; i++)
		begin
			totalChecks += checkCount[i];
			totalErrors += errorCount[i];
		end
		$display("requests %0d, checks %0d, errors %0d, stray responses %0d",
			issuedCount, totalChecks, totalErrors, strayCount);
		if (totalErrors == 0 && strayCount == 0 && totalChecks == issuedCount)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+dv
design/tlbBusPkg.sv
design/tlbEntryPkg.sv
design/tlbStageIf.sv
design/tlbRequestStage.sv
design/tlbWayStore.sv
design/tlbMatchStage.sv
design/mmuTlb.sv
dv/tlbTb.sv

// File: run.sh
#!/bin/sh
# build the TLB testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tlbTb -f compile.f -o tlbSim \
	&& ./obj_dir/tlbSim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TEST PASSED" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
